//--- verif/commit_trace_patterns.txt
# t ice rce id0 id1 push ab0 as0 ab1 as1 rp0 rp1 f0 f1 h0 h1 we0 we1 lrd0 lrd1 exc vect pce irr
#   then chk ev0 ei0 ew0 ex0 eirr0 ev1 ei1 ew1 (all hex, expectations for the next record)
1 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0  1 0 0 0 0 0 0 0 0
1 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0  1 0 0 0 0 0 0 0 0
2 1 0 1001 1002 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0  0 0 0 0 0 0 0 0 0
2 1 1 2001 2002 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0  0 0 0 0 0 0 0 0 0
2 0 0 dead beef 2 0 0 1 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0  0 0 0 0 0 0 0 0 0
2 0 0 dead beef 0 0 0 0 0 0 0 1 1 0 1 1 1 3 4 0 0 0 0  1 1 1001 1 0 0 1 1002 1
2 0 1 dead beef 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0  1 0 0 0 0 0 0 0 0
2 0 0 dead beef 2 0 1 1 1 0 0 0 0 0 0 0 0 0 0 0 0 0 0  1 0 0 0 0 0 0 0 0
2 0 0 dead beef 0 0 0 0 0 1 1 1 1 0 1 0 1 0 5 0 0 0 0  1 1 2001 0 0 0 1 2002 1
3 1 0 3001 3002 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0  0 0 0 0 0 0 0 0 0
3 0 1 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0  0 0 0 0 0 0 0 0 0
3 0 0 0 0 2 1 2 0 2 0 0 0 0 0 0 0 0 0 0 0 0 0 0  0 0 0 0 0 0 0 0 0
3 0 0 0 0 0 0 0 0 0 2 2 1 1 1 0 1 0 6 0 0 0 0 0  1 1 3001 1 0 0 1 3002 0
4 1 0 4001 4002 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0  0 0 0 0 0 0 0 0 0
4 1 1 5001 5002 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0  0 0 0 0 0 0 0 0 0
4 0 0 0 0 2 0 3 1 3 0 0 0 0 0 0 0 0 0 0 0 0 0 0  0 0 0 0 0 0 0 0 0
4 0 1 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0  0 0 0 0 0 0 0 0 0
4 0 0 0 0 1 0 3 1 3 0 0 0 0 0 0 0 0 0 0 0 0 0 0  0 0 0 0 0 0 0 0 0
4 0 0 0 0 0 0 0 0 0 3 3 1 1 0 1 0 0 0 0 0 0 0 0  1 1 5001 0 0 0 1 4002 0
5 0 0 0 0 0 0 0 0 0 0 0 1 0 0 0 0 0 0 0 1 80 0 0  1 1 1001 0 1 0 0 0 0
5 0 0 0 0 0 0 0 0 0 2 2 1 1 0 1 1 1 7 9 0 0 0 0  1 1 3002 1 0 0 1 3001 1
6 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 1 a5  1 0 0 0 0 0 0 0 0
6 0 0 0 0 0 0 0 0 0 0 0 1 0 0 0 0 0 0 0 0 0 0 3c  1 1 1001 0 0 a5 0 0 0
6 0 0 0 0 0 0 0 0 0 0 0 1 0 0 0 1 0 2 0 0 0 0 ff  1 1 1001 1 0 a5 0 0 0
6 0 0 0 0 0 0 0 0 0 0 0 1 0 0 0 0 0 0 0 0 0 1 12  1 1 1001 0 0 a5 0 0 0
6 0 0 0 0 0 0 0 0 0 0 0 1 1 0 1 0 0 0 0 0 0 0 0  1 1 1001 0 0 12 1 1002 0
6 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0  1 0 0 0 0 0 0 0 0

//--- list.f
+incdir+design
design/rob_pkg.sv
design/trace_pkg.sv
design/insn_capture.sv
design/insn_shadow_bank.sv
design/commit_trace_reg.sv
design/commit_trace_top.sv
verif/commit_trace_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the commit trace testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing -f list.f --top-module commit_trace_tb -o commit_trace_sim
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

./obj_dir/commit_trace_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
   echo "Simulation exited with status $status"
   exit 1
fi

if grep -q "TESTS FAILED" "$LOG"; then
   exit 1
fi

if ! grep -q "TESTS PASSED" "$LOG"; then
   echo "Simulation log has no result line"
   exit 1
fi

exit 0

//--- verif/commit_trace_tb.sv
`include "trace_settings.svh"

module commit_trace_tb
   import rob_pkg::*;
   import trace_pkg::*;
();

   localparam int NUM_FIELDS = 33;
   localparam int MAX_CYCLES = 200;

   logic                             clk;
   logic                             rst_n;
   insn_word_t  [`TRACE_LANES-1:0]   id_ins;
   logic                             id_p_ce;
   logic                             rn_p_ce;
   lane_alloc_t [`TRACE_LANES-1:0]   alloc;
   push_size_t                       push_size;
   slot_id_t    [`TRACE_LANES-1:0]   rptr;
   logic        [`TRACE_LANES-1:0]   cmt_fire;
   bank_id_t    [`TRACE_LANES-1:0]   head_l;
   pc_t         [`TRACE_LANES-1:0]   cmt_pc;
   reg_id_t     [`TRACE_LANES-1:0]   cmt_lrd;
   data_t       [`TRACE_LANES-1:0]   cmt_lrd_dat;
   logic        [`TRACE_LANES-1:0]   cmt_lrd_we;
   logic                             cmt_exc;
   data_t                            cmt_exc_vect;
   logic                             cmt_p_ce;
   irq_vec_t                         irqc_irr;
   commit_rec_t [`TRACE_LANES-1:0]   commit;

   // One parsed line of the pattern file
   logic [31:0] fld [NUM_FIELDS];

   // Expectations for the record that follows the last driven line
   bit          pend_chk;
   logic [31:0] exp_valid [`TRACE_LANES];
   logic [31:0] exp_insn [`TRACE_LANES];
   logic [31:0] exp_wen [`TRACE_LANES];
   logic [31:0] exp_exc0;
   logic [31:0] exp_irr0;

   integer seed;
   integer fd;
   int     cur_test;
   int     test_errors;
   int     errors;
   int     tests_run;
   int     tests_failed;
   int     cycles;
   bit     timed_out;
   bit     got;

   commit_trace_top commit_trace_top_i (
      .clk          (clk),
      .rst_n        (rst_n),
      .id_ins       (id_ins),
      .id_p_ce      (id_p_ce),
      .rn_p_ce      (rn_p_ce),
      .alloc        (alloc),
      .push_size    (push_size),
      .rptr         (rptr),
      .cmt_fire     (cmt_fire),
      .head_l       (head_l),
      .cmt_pc       (cmt_pc),
      .cmt_lrd      (cmt_lrd),
      .cmt_lrd_dat  (cmt_lrd_dat),
      .cmt_lrd_we   (cmt_lrd_we),
      .cmt_exc      (cmt_exc),
      .cmt_exc_vect (cmt_exc_vect),
      .cmt_p_ce     (cmt_p_ce),
      .irqc_irr     (irqc_irr),
      .commit       (commit)
   );

   initial
   begin
      clk = 1'b0;
   end

   always #50 clk = ~clk;

   task automatic report_mismatch(input string name, input int lane,
                                  input logic [31:0] expv, input logic [31:0] actv);
      errors++;
      test_errors++;
      $display("Error: commit[%0d].%s expected %h, got %h", lane, name, expv, actv);
   endtask

   // Valid and wen must be cleared by reset alone
   task automatic check_reset_state();
      for (int i = 0; i < `TRACE_LANES; i++)
      begin
         if (commit[i].valid !== 1'b0)
            report_mismatch("valid", i, 32'd0, 32'(commit[i].valid));
         if (commit[i].wen !== 1'b0)
            report_mismatch("wen", i, 32'd0, 32'(commit[i].wen));
      end
   endtask

   // Inputs still hold the values of the line being checked
   task automatic check_record();
      for (int i = 0; i < `TRACE_LANES; i++)
      begin
         if (32'(commit[i].valid) !== exp_valid[i])
            report_mismatch("valid", i, exp_valid[i], 32'(commit[i].valid));
         if (32'(commit[i].wen) !== exp_wen[i])
            report_mismatch("wen", i, exp_wen[i], 32'(commit[i].wen));
         if (exp_valid[i] == 32'd1)
         begin
            if (32'(commit[i].insn) !== exp_insn[i])
               report_mismatch("insn", i, exp_insn[i], 32'(commit[i].insn));
            if (32'(commit[i].pc) !== 32'(cmt_pc[i]))
               report_mismatch("pc", i, 32'(cmt_pc[i]), 32'(commit[i].pc));
            if (32'(commit[i].wnum) !== 32'(cmt_lrd[i]))
               report_mismatch("wnum", i, 32'(cmt_lrd[i]), 32'(commit[i].wnum));
            if (i == 0 && exp_exc0 == 32'd1)
            begin
               if (commit[i].result.exc_vect !== cmt_exc_vect)
                  report_mismatch("result.exc_vect", i, cmt_exc_vect,
                                  commit[i].result.exc_vect);
            end
            else
            begin
               if (commit[i].result.wdata !== cmt_lrd_dat[i])
                  report_mismatch("result.wdata", i, cmt_lrd_dat[i], commit[i].result.wdata);
            end
            if (i == 0)
            begin
               if (32'(commit[i].exc) !== exp_exc0)
                  report_mismatch("exc", i, exp_exc0, 32'(commit[i].exc));
               if (32'(commit[i].irqc_irr) !== exp_irr0)
                  report_mismatch("irqc_irr", i, exp_irr0, 32'(commit[i].irqc_irr));
            end
            else
            begin
               if (commit[i].exc !== 1'b0)
                  report_mismatch("exc", i, 32'd0, 32'(commit[i].exc));
               if (commit[i].irqc_irr !== '0)
                  report_mismatch("irqc_irr", i, 32'd0, 32'(commit[i].irqc_irr));
            end
         end
      end
   endtask

   // Skips comment lines, stops at the next data line or at end of file
   task automatic read_pattern(output bit found);
      string line;
      int    n;
      found = 1'b0;
      while (!found && !$feof(fd))
      begin
         line = "";
         n = $fgets(line, fd);
         if (n > 0 && line.len() > 1 && line.substr(0, 0) != "#")
         begin
            n = $sscanf(line,
               "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
               fld[0], fld[1], fld[2], fld[3], fld[4], fld[5], fld[6], fld[7], fld[8],
               fld[9], fld[10], fld[11], fld[12], fld[13], fld[14], fld[15], fld[16],
               fld[17], fld[18], fld[19], fld[20], fld[21], fld[22], fld[23], fld[24],
               fld[25], fld[26], fld[27], fld[28], fld[29], fld[30], fld[31], fld[32]);
            if (n == NUM_FIELDS)
            begin
               found = 1'b1;
            end
            else
            begin
               errors++;
               test_errors++;
               $display("pattern line has %0d fields instead of %0d", n, NUM_FIELDS);
            end
         end
      end
   endtask

   task automatic drive_pattern();
      id_p_ce      = fld[1][0];
      rn_p_ce      = fld[2][0];
      push_size    = push_size_t'(fld[5]);
      cmt_exc      = fld[20][0];
      cmt_exc_vect = data_t'(fld[21]);
      cmt_p_ce     = fld[22][0];
      irqc_irr     = irq_vec_t'(fld[23]);
      for (int i = 0; i < `TRACE_LANES; i++)
      begin
         id_ins[i]      = insn_word_t'(fld[3+i]);
         alloc[i].bank  = bank_id_t'(fld[6+2*i]);
         alloc[i].slot  = slot_id_t'(fld[7+2*i]);
         rptr[i]        = slot_id_t'(fld[10+i]);
         cmt_fire[i]    = fld[12+i][0];
         head_l[i]      = bank_id_t'(fld[14+i]);
         cmt_lrd_we[i]  = fld[16+i][0];
         cmt_lrd[i]     = reg_id_t'(fld[18+i]);
         cmt_pc[i]      = pc_t'($random(seed));
         cmt_lrd_dat[i] = data_t'($random(seed));
      end
      pend_chk     = fld[24][0];
      exp_valid[0] = fld[25];
      exp_insn[0]  = fld[26];
      exp_wen[0]   = fld[27];
      exp_exc0     = fld[28];
      exp_irr0     = fld[29];
      exp_valid[1] = fld[30];
      exp_insn[1]  = fld[31];
      exp_wen[1]   = fld[32];
   endtask

   task automatic close_test();
      tests_run++;
      if (test_errors == 0)
      begin
         $display("test %0d ok", cur_test);
      end
      else
      begin
         tests_failed++;
         $display("test %0d failed with %0d errors", cur_test, test_errors);
      end
      test_errors = 0;
   endtask

   initial
   begin
      seed         = 72;
      rst_n        = 1'b0;
      id_ins       = '0;
      id_p_ce      = 1'b0;
      rn_p_ce      = 1'b0;
      alloc        = '0;
      push_size    = '0;
      rptr         = '0;
      // Commits requested during reset, so only reset keeps valid and wen low
      cmt_fire     = '1;
      head_l       = '0;
      cmt_pc       = '0;
      cmt_lrd      = '0;
      cmt_lrd_dat  = '0;
      cmt_lrd_we   = '1;
      cmt_exc      = 1'b0;
      cmt_exc_vect = '0;
      // Loads a known interrupt sample during reset
      cmt_p_ce     = 1'b1;
      irqc_irr     = '0;
      pend_chk     = 1'b0;
      cur_test     = -1;
      test_errors  = 0;
      errors       = 0;
      tests_run    = 0;
      tests_failed = 0;
      cycles       = 0;
      timed_out    = 1'b0;
      got          = 1'b1;

      fd = $fopen("verif/commit_trace_patterns.txt", "r");
      if (fd == 0)
      begin
         $display("cannot open the pattern file");
      end
      else
      begin
         for (int n = 0; n < 3; n++)
         begin
            @(posedge clk);
         end
         @(negedge clk);
         check_reset_state();
         rst_n      = 1'b1;
         cmt_fire   = '0;
         cmt_lrd_we = '0;
         cmt_p_ce   = 1'b0;

         while (got && !timed_out)
         begin
            read_pattern(got);
            if (pend_chk)
            begin
               check_record();
            end
            pend_chk = 1'b0;
            if (got)
            begin
               if (int'(fld[0]) != cur_test)
               begin
                  if (cur_test >= 0)
                  begin
                     close_test();
                  end
                  cur_test = int'(fld[0]);
               end
               drive_pattern();
               @(negedge clk);
               cycles++;
               if (cycles >= MAX_CYCLES)
               begin
                  timed_out = 1'b1;
                  $display("timeout: pattern list did not end within %0d cycles", MAX_CYCLES);
               end
            end
         end
         if (cur_test >= 0)
         begin
            close_test();
         end
         $fclose(fd);
      end

      $display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, errors);
      if (fd == 0 || timed_out || errors != 0 || tests_failed != 0)
      begin
         $display("TESTS FAILED");
      end
      else
      begin
         $display("TESTS PASSED");
      end
      $finish;
   end

endmodule

//--- design/commit_trace_top.sv
`include "trace_settings.svh"

module commit_trace_top
   import rob_pkg::*;
   import trace_pkg::*;
(
   input  logic                             clk,
   input  logic                             rst_n,
   input  insn_word_t  [`TRACE_LANES-1:0]   id_ins,
   input  logic                             id_p_ce,
   input  logic                             rn_p_ce,
   input  lane_alloc_t [`TRACE_LANES-1:0]   alloc,
   input  push_size_t                       push_size,
   input  slot_id_t    [`TRACE_LANES-1:0]   rptr,
   input  logic        [`TRACE_LANES-1:0]   cmt_fire,
   input  bank_id_t    [`TRACE_LANES-1:0]   head_l,
   input  pc_t         [`TRACE_LANES-1:0]   cmt_pc,
   input  reg_id_t     [`TRACE_LANES-1:0]   cmt_lrd,
   input  data_t       [`TRACE_LANES-1:0]   cmt_lrd_dat,
   input  logic        [`TRACE_LANES-1:0]   cmt_lrd_we,
   input  logic                             cmt_exc,
   input  data_t                            cmt_exc_vect,
   input  logic                             cmt_p_ce,
   input  irq_vec_t                         irqc_irr,
   output commit_rec_t [`TRACE_LANES-1:0]   commit
);

   bank_write_t [`TRACE_LANES-1:0] bank_wr;
   insn_word_t  [`TRACE_LANES-1:0] bank_word;

   insn_capture insn_capture_i (
      .clk       (clk),
      .id_ins    (id_ins),
      .id_p_ce   (id_p_ce),
      .rn_p_ce   (rn_p_ce),
      .alloc     (alloc),
      .push_size (push_size),
      .bank_wr   (bank_wr)
   );

   // One shadow bank per ROB bank
   for (genvar b = 0; b < `TRACE_LANES; b++)
   begin : g_bank
      insn_shadow_bank insn_shadow_bank_i (
         .clk     (clk),
         .wr      (bank_wr[b]),
         .rptr    (rptr[b]),
         .rd_word (bank_word[b])
      );
   end

   commit_trace_reg commit_trace_reg_i (
      .clk          (clk),
      .rst_n        (rst_n),
      .bank_word    (bank_word),
      .head_l       (head_l),
      .cmt_fire     (cmt_fire),
      .cmt_pc       (cmt_pc),
      .cmt_lrd      (cmt_lrd),
      .cmt_lrd_dat  (cmt_lrd_dat),
      .cmt_lrd_we   (cmt_lrd_we),
      .cmt_exc      (cmt_exc),
      .cmt_exc_vect (cmt_exc_vect),
      .cmt_p_ce     (cmt_p_ce),
      .irqc_irr     (irqc_irr),
      .commit       (commit)
   );

endmodule

//--- design/commit_trace_reg.sv
`include "trace_settings.svh"

module commit_trace_reg
   import rob_pkg::*;
   import trace_pkg::*;
(
   input  logic                             clk,
   input  logic                             rst_n,
   input  insn_word_t  [`TRACE_LANES-1:0]   bank_word,
   input  bank_id_t    [`TRACE_LANES-1:0]   head_l,
   input  logic        [`TRACE_LANES-1:0]   cmt_fire,
   input  pc_t         [`TRACE_LANES-1:0]   cmt_pc,
   input  reg_id_t     [`TRACE_LANES-1:0]   cmt_lrd,
   input  data_t       [`TRACE_LANES-1:0]   cmt_lrd_dat,
   input  logic        [`TRACE_LANES-1:0]   cmt_lrd_we,
   input  logic                             cmt_exc,
   input  data_t                            cmt_exc_vect,
   input  logic                             cmt_p_ce,
   input  irq_vec_t                         irqc_irr,
   output commit_rec_t [`TRACE_LANES-1:0]   commit
);

   irq_vec_t                         irq_s1;
   commit_rec_t [`TRACE_LANES-1:0]   rec_next;

   // Interrupt state follows the commit pipeline by one stage
   always_ff @(posedge clk)
   begin
      if (cmt_p_ce)
      begin
         irq_s1 <= irqc_irr;
      end
   end

   always_comb
   begin
      for (int i = 0; i < `TRACE_LANES; i++)
      begin
         rec_next[i].valid        = cmt_fire[i];
         rec_next[i].pc           = cmt_pc[i];
         // Lane i reads whichever bank holds its head
         rec_next[i].insn         = bank_word[head_l[i]];
         rec_next[i].wen          = cmt_lrd_we[i];
         rec_next[i].wnum         = cmt_lrd[i];
         rec_next[i].exc          = 1'b0;
         rec_next[i].result.wdata = cmt_lrd_dat[i];
         rec_next[i].irqc_irr     = '0;
      end

      // Exceptions and interrupts only ever land on lane 0
      rec_next[0].exc      = cmt_exc;
      rec_next[0].irqc_irr = irq_s1;
      if (cmt_exc)
      begin
         rec_next[0].result.exc_vect = cmt_exc_vect;
      end
   end

   always_ff @(posedge clk)
   begin
      commit <= rec_next;
      if (!rst_n)
      begin
         for (int i = 0; i < `TRACE_LANES; i++)
         begin
            commit[i].valid <= 1'b0;
            commit[i].wen   <= 1'b0;
         end
      end
   end

   for (genvar i = 0; i < `TRACE_LANES; i++)
   begin : g_lane_chk
      // A register write in the trace must belong to a committed lane
      a_wen_has_valid : assert property (
         @(posedge clk) disable iff (!rst_n)
         commit[i].wen |-> commit[i].valid
      ) else $error("lane %0d shows wen without valid", i);
   end

   a_exc_on_lane0 : assert property (
      @(posedge clk) disable iff (!rst_n)
      cmt_exc |-> cmt_fire[0]
   ) else $error("cmt_exc without a lane 0 commit");

endmodule

//--- design/insn_shadow_bank.sv
`include "trace_settings.svh"

module insn_shadow_bank
   import rob_pkg::*;
(
   input  logic        clk,
   input  bank_write_t wr,
   input  slot_id_t    rptr,
   output insn_word_t  rd_word
);

   localparam int DEPTH = 1 << `TRACE_SLOT_AW;

   // Raw words, parallel to this bank's ROB entries
   insn_word_t mem [DEPTH];

   always_ff @(posedge clk)
   begin
      if (wr.en)
      begin
         mem[wr.slot] <= wr.word;
      end
   end

   // Asynchronous read at the bank's head
   assign rd_word = mem[rptr];

endmodule

//--- design/insn_capture.sv
`include "trace_settings.svh"

module insn_capture
   import rob_pkg::*;
(
   input  logic                              clk,
   input  insn_word_t  [`TRACE_LANES-1:0]    id_ins,
   input  logic                              id_p_ce,
   input  logic                              rn_p_ce,
   input  lane_alloc_t [`TRACE_LANES-1:0]    alloc,
   input  push_size_t                        push_size,
   output bank_write_t [`TRACE_LANES-1:0]    bank_wr
);

   insn_word_t [`TRACE_LANES-1:0] rn_ins;
   insn_word_t [`TRACE_LANES-1:0] issue_ins;
   logic       [`TRACE_LANES-1:0] lane_push;
   logic       [`TRACE_LANES-1:0] bank_multi;

   // Shadows of the decode and rename pipeline registers
   always_ff @(posedge clk)
   begin
      if (id_p_ce)
      begin
         rn_ins <= id_ins;
      end
      if (rn_p_ce)
      begin
         issue_ins <= rn_ins;
      end
   end

   // Lanes below push_size are the ones entering the ROB
   always_comb
   begin
      for (int i = 0; i < `TRACE_LANES; i++)
      begin
         lane_push[i] = push_size > push_size_t'(i);
      end
   end

   // Turn lane-indexed allocations into one request per bank
   always_comb
   begin
      bank_multi = '0;
      for (int b = 0; b < `TRACE_LANES; b++)
      begin
         bank_wr[b] = '0;
         for (int i = 0; i < `TRACE_LANES; i++)
         begin
            if (lane_push[i] && (alloc[i].bank == bank_id_t'(b)))
            begin
               if (bank_wr[b].en)
               begin
                  bank_multi[b] = 1'b1;
               end
               bank_wr[b].en   = 1'b1;
               bank_wr[b].slot = alloc[i].slot;
               bank_wr[b].word = issue_ins[i];
            end
         end
      end
   end

   // ROB must spread one push over distinct banks
   a_one_lane_per_bank : assert property (@(posedge clk) bank_multi == '0)
      else $error("two pushing lanes name the same bank");

endmodule

//--- design/trace_pkg.sv
`include "trace_settings.svh"

package trace_pkg;

   typedef logic [`TRACE_PC_W-1:0] pc_t;

   typedef logic [`TRACE_LRF_AW-1:0] reg_id_t;

   typedef logic [`TRACE_DW-1:0] data_t;

   typedef logic [`TRACE_NUM_IRQ-1:0] irq_vec_t;

   // Same word, read as write data or as the exception vector
   // depending on the record's exc flag
   typedef union packed {
      data_t wdata;
      data_t exc_vect;
   } trace_result_u;

   // One lane of the commit trace
   typedef struct packed {
      logic                valid;
      pc_t                 pc;
      rob_pkg::insn_word_t insn;
      logic                wen;
      reg_id_t             wnum;
      logic                exc;
      trace_result_u       result;
      irq_vec_t            irqc_irr;
   } commit_rec_t;

endpackage

//--- design/rob_pkg.sv
`include "trace_settings.svh"

package rob_pkg;

   // Bank index is at least one bit wide
   localparam int BANK_AW = (`TRACE_LANES > 1) ? $clog2(`TRACE_LANES) : 1;

   // Push count ranges over 0 to TRACE_LANES
   localparam int PUSH_W = $clog2(`TRACE_LANES + 1);

   typedef logic [`TRACE_INSN_W-1:0] insn_word_t;

   typedef logic [`TRACE_SLOT_AW-1:0] slot_id_t;

   typedef logic [BANK_AW-1:0] bank_id_t;

   typedef logic [PUSH_W-1:0] push_size_t;

   // Where the ROB placed one issuing lane
   typedef struct packed {
      bank_id_t bank;
      slot_id_t slot;
   } lane_alloc_t;

   // One write into one shadow bank
   typedef struct packed {
      logic       en;
      slot_id_t   slot;
      insn_word_t word;
   } bank_write_t;

endpackage

//--- design/trace_settings.svh
`ifndef TRACE_SETTINGS_SVH
`define TRACE_SETTINGS_SVH

// Lanes, commit width and bank count are one and the same
`define TRACE_LANES 2

// 8 slots per bank
`define TRACE_SLOT_AW 3

// Word-aligned pc
`define TRACE_PC_W 30

`define TRACE_DW 32

// Architectural register address
`define TRACE_LRF_AW 5

`define TRACE_NUM_IRQ 8

`define TRACE_INSN_W 32

`endif
